// ==== build.f ====
rtl/eco_pkg.sv
rtl/busctrl.sv
rtl/ram.sv
rtl/tmr.sv
rtl/bio.sv
rtl/eco_io.sv
verif/tb_eco_io.sv

// ==== rtl/bio.sv ====
/* board I/O: LED register at offset 0, switches read at offset 4.
   switches pass a two-flop synchronizer, so a change shows 2 clocks later */
`default_nettype none

module bio (
  input  logic              clk,
  input  logic              reset,
  input  eco_pkg::bus_req_t req,
  output eco_pkg::bus_rsp_t rsp,
  input  logic [3:0]        sw,
  output logic [7:0]        led
);

  logic [3:0]  sw_meta;
  logic [3:0]  sw_sync;
  logic [31:0] rd_data;
  logic        wr_led;

  // switch register is read only
  assign wr_led = req.en & req.wr & ~req.addr[2];

  always_ff @(posedge clk) begin
    if (reset) begin
      led <= 8'h00;
    end else if (wr_led) begin
      led <= req.data[7:0];
    end
  end

  // async switch inputs
  always_ff @(posedge clk) begin
    sw_meta <= sw;
    sw_sync <= sw_meta;
  end

  always_comb begin
    if (req.addr[2]) begin
      rd_data = {28'h0000000, sw_sync};
    end else begin
      rd_data = {24'h000000, led};
    end
  end

  assign rsp = '{data: rd_data, wt: 1'b0};

endmodule

`default_nettype wire

// ==== rtl/busctrl.sv ====
/* combinational address decoder and response mux, adds no cycles.
   unmapped addresses complete at once: reads return zero, writes are dropped */
`default_nettype none

module busctrl (
  input  eco_pkg::bus_req_t bus_req,
  output eco_pkg::bus_rsp_t bus_rsp,
  // ram
  output eco_pkg::bus_req_t ram_req,
  input  eco_pkg::bus_rsp_t ram_rsp,
  // tmr0
  output eco_pkg::bus_req_t tmr0_req,
  input  eco_pkg::bus_rsp_t tmr0_rsp,
  // tmr1
  output eco_pkg::bus_req_t tmr1_req,
  input  eco_pkg::bus_rsp_t tmr1_rsp,
  // bio
  output eco_pkg::bus_req_t bio_req,
  input  eco_pkg::bus_rsp_t bio_rsp
);

  eco_pkg::dev_sel_e sel;

  // copy of the request with en kept only for the selected device
  function automatic eco_pkg::bus_req_t route(input eco_pkg::bus_req_t r,
                                              input logic hit);
    eco_pkg::bus_req_t o;
    o = r;
    o.en = r.en & hit;
    return o;
  endfunction

  // ram spans 4 KB, timers 16 bytes, bio 8 bytes
  always_comb begin
    if (bus_req.addr[31:eco_pkg::ram_aw+2] ==
        eco_pkg::ram_base[31:eco_pkg::ram_aw+2]) begin
      sel = eco_pkg::dev_ram;
    end else if (bus_req.addr[31:4] == eco_pkg::tmr0_base[31:4]) begin
      sel = eco_pkg::dev_tmr0;
    end else if (bus_req.addr[31:4] == eco_pkg::tmr1_base[31:4]) begin
      sel = eco_pkg::dev_tmr1;
    end else if (bus_req.addr[31:3] == eco_pkg::bio_base[31:3]) begin
      sel = eco_pkg::dev_bio;
    end else begin
      sel = eco_pkg::dev_none;
    end
  end

  assign ram_req  = route(bus_req, sel == eco_pkg::dev_ram);
  assign tmr0_req = route(bus_req, sel == eco_pkg::dev_tmr0);
  assign tmr1_req = route(bus_req, sel == eco_pkg::dev_tmr1);
  assign bio_req  = route(bus_req, sel == eco_pkg::dev_bio);

  always_comb begin
    case (sel)
      eco_pkg::dev_ram: begin
        bus_rsp = ram_rsp;
      end
      eco_pkg::dev_tmr0: begin
        bus_rsp = tmr0_rsp;
      end
      eco_pkg::dev_tmr1: begin
        bus_rsp = tmr1_rsp;
      end
      eco_pkg::dev_bio: begin
        bus_rsp = bio_rsp;
      end
      default: begin
        // nothing there, finish immediately
        bus_rsp = '{data: 32'h0000_0000, wt: 1'b0};
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/eco_io.sv ====
/* I/O subsystem top: bus controller, RAM, two timers and board I/O.
   the bus master is external; timer interrupts leave as irq */
`default_nettype none

module eco_io (
  input  logic              clk,
  input  logic              reset,
  input  eco_pkg::bus_req_t bus_req,
  output eco_pkg::bus_rsp_t bus_rsp,
  input  logic [3:0]        sw,
  output logic [7:0]        led,
  output eco_pkg::irq_t     irq
);

  // ram
  eco_pkg::bus_req_t ram_req;
  eco_pkg::bus_rsp_t ram_rsp;
  // tmr0
  eco_pkg::bus_req_t tmr0_req;
  eco_pkg::bus_rsp_t tmr0_rsp;
  logic              tmr0_irq;
  // tmr1
  eco_pkg::bus_req_t tmr1_req;
  eco_pkg::bus_rsp_t tmr1_rsp;
  logic              tmr1_irq;
  // bio
  eco_pkg::bus_req_t bio_req;
  eco_pkg::bus_rsp_t bio_rsp;

  busctrl u_busctrl (
    .bus_req  (bus_req),
    .bus_rsp  (bus_rsp),
    .ram_req  (ram_req),
    .ram_rsp  (ram_rsp),
    .tmr0_req (tmr0_req),
    .tmr0_rsp (tmr0_rsp),
    .tmr1_req (tmr1_req),
    .tmr1_rsp (tmr1_rsp),
    .bio_req  (bio_req),
    .bio_rsp  (bio_rsp)
  );

  ram u_ram (
    .clk   (clk),
    .reset (reset),
    .req   (ram_req),
    .rsp   (ram_rsp)
  );

  tmr u_tmr0 (
    .clk   (clk),
    .reset (reset),
    .req   (tmr0_req),
    .rsp   (tmr0_rsp),
    .irq   (tmr0_irq)
  );

  tmr u_tmr1 (
    .clk   (clk),
    .reset (reset),
    .req   (tmr1_req),
    .rsp   (tmr1_rsp),
    .irq   (tmr1_irq)
  );

  bio u_bio (
    .clk   (clk),
    .reset (reset),
    .req   (bio_req),
    .rsp   (bio_rsp),
    .sw    (sw),
    .led   (led)
  );

  assign irq = '{tmr0: tmr0_irq, tmr1: tmr1_irq};

endmodule

`default_nettype wire

// ==== rtl/eco_pkg.sv ====
/* bus types, address map and RAM size shared by the I/O subsystem.
   size encoding follows ECO32: 00 byte, 01 half-word, 10 word */
`default_nettype none

package eco_pkg;

  typedef enum logic [1:0] {
    sz_byte = 2'b00,
    sz_half = 2'b01,
    sz_word = 2'b10
  } bus_size_e;

  // decoded bus target
  typedef enum logic [2:0] {
    dev_ram,
    dev_tmr0,
    dev_tmr1,
    dev_bio,
    dev_none
  } dev_sel_e;

  // request from the master, same fields go to every device
  typedef struct packed {
    logic        en;
    logic        wr;
    bus_size_e   size;
    logic [31:0] addr;
    logic [31:0] data;
  } bus_req_t;

  typedef struct packed {
    logic [31:0] data;
    logic        wt;
  } bus_rsp_t;

  typedef struct packed {
    logic tmr0;
    logic tmr1;
  } irq_t;

  // address map
  localparam logic [31:0] ram_base  = 32'h0000_0000;
  localparam logic [31:0] tmr0_base = 32'hF000_0000;
  localparam logic [31:0] tmr1_base = 32'hF000_1000;
  localparam logic [31:0] bio_base  = 32'hF100_0000;

  // on-chip RAM, 4 KB of words
  localparam int ram_words = 1024;
  localparam int ram_aw    = 10;

endpackage

`default_nettype wire

// ==== rtl/ram.sv ====
/* on-chip word RAM, big-endian byte lanes as on ECO32 (byte 0 in bits 31:24).
   write data is right-justified; writes take 1 cycle, reads 2 with wt high
   in the first. misaligned low address bits are ignored, contents not reset */
`default_nettype none

module ram (
  input  logic              clk,
  input  logic              reset,
  input  eco_pkg::bus_req_t req,
  output eco_pkg::bus_rsp_t rsp
);

  logic [31:0] mem [eco_pkg::ram_words];

  logic [eco_pkg::ram_aw-1:0] waddr;
  logic [3:0]  be;
  logic [31:0] wdata;
  logic [31:0] rd_word;
  logic [31:0] rd_data;
  logic        rd_wait;
  logic        rd_start;

  assign waddr    = req.addr[eco_pkg::ram_aw+1:2];
  assign rd_start = req.en & ~req.wr & ~rd_wait;

  // lane enables and replicated write data
  always_comb begin
    case (req.size)
      eco_pkg::sz_byte: begin
        be    = 4'b1000 >> req.addr[1:0];
        wdata = {4{req.data[7:0]}};
      end
      eco_pkg::sz_half: begin
        be    = req.addr[1] ? 4'b0011 : 4'b1100;
        wdata = {2{req.data[15:0]}};
      end
      default: begin
        be    = 4'b1111;
        wdata = req.data;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (req.en & req.wr) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) begin
          mem[waddr][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
    if (rd_start) begin
      rd_word <= mem[waddr];
    end
  end

  // one wait state on reads
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_wait <= 1'b0;
    end else begin
      rd_wait <= rd_start;
    end
  end

  // right-justify and zero-extend
  always_comb begin
    case (req.size)
      eco_pkg::sz_byte: begin
        rd_data = {24'h000000, 8'(rd_word >> {~req.addr[1:0], 3'b000})};
      end
      eco_pkg::sz_half: begin
        rd_data = {16'h0000, 16'(rd_word >> {~req.addr[1], 4'b0000})};
      end
      default: begin
        rd_data = rd_word;
      end
    endcase
  end

  assign rsp = '{data: rd_data, wt: rd_start};

endmodule

`default_nettype wire

// ==== rtl/tmr.sv ====
/* interval timer: control (ien, expired) at 0, divisor at 4, counter at 8.
   expired is set divisor clocks after a divisor write, then every period.
   every access completes in one cycle */
`default_nettype none

module tmr (
  input  logic              clk,
  input  logic              reset,
  input  eco_pkg::bus_req_t req,
  output eco_pkg::bus_rsp_t rsp,
  output logic              irq
);

  logic        ien;
  logic        expired;
  logic [31:0] divisor;
  logic [31:0] counter;
  logic [31:0] rd_data;
  logic        wr_ctrl;
  logic        wr_div;
  logic        reload;

  assign wr_ctrl = req.en & req.wr & (req.addr[3:2] == 2'd0);
  assign wr_div  = req.en & req.wr & (req.addr[3:2] == 2'd1);

  // period boundary, a divisor write takes precedence
  assign reload = ~wr_div & (counter == 32'd1);

  always_ff @(posedge clk) begin
    if (reset) begin
      divisor <= 32'hFFFF_FFFF;
    end else if (wr_div) begin
      divisor <= req.data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      counter <= 32'hFFFF_FFFF;
    end else if (wr_div) begin
      counter <= req.data;
    end else if (reload) begin
      counter <= divisor;
    end else begin
      counter <= counter - 32'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ien <= 1'b0;
    end else if (wr_ctrl) begin
      ien <= req.data[0];
    end
  end

  // a new expiry in the same cycle as a control write is kept
  always_ff @(posedge clk) begin
    if (reset) begin
      expired <= 1'b0;
    end else if (reload) begin
      expired <= 1'b1;
    end else if (wr_ctrl) begin
      expired <= 1'b0;
    end
  end

  always_comb begin
    case (req.addr[3:2])
      2'd0: begin
        rd_data = {30'h0000_0000, expired, ien};
      end
      2'd1: begin
        rd_data = divisor;
      end
      2'd2: begin
        rd_data = counter;
      end
      default: begin
        rd_data = 32'h0000_0000;
      end
    endcase
  end

  assign rsp = '{data: rd_data, wt: 1'b0};
  assign irq = expired & ien;

endmodule

`default_nettype wire

// ==== verif/tb_eco_io.sv ====
/* testbench for the I/O subsystem; acts as the bus master.
   RAM model is big-endian with byte 0 in bits 31:24.
   every transfer starts 1 unit after a rising edge */
`default_nettype none

module tb_eco_io;

  localparam int timeout_cycles = 3000;

  logic              clk;
  logic              reset;
  eco_pkg::bus_req_t bus_req;
  eco_pkg::bus_rsp_t bus_rsp;
  logic [3:0]        sw;
  logic [7:0]        led;
  eco_pkg::irq_t     irq;

  logic [7:0] shadow [4096];
  integer     seed;
  int         cycle;
  logic [7:0] led_val;

  eco_io u_dut (
    .clk     (clk),
    .reset   (reset),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .sw      (sw),
    .led     (led),
    .irq     (irq)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= timeout_cycles) begin
      $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
      $display("Checks failed");
      $fatal(1);
    end
  end

  task automatic report_fail(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    $display("Fail %s got %h expected %h", name, got, exp);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else report_fail(name, got, exp);
  endtask

  // timer and bio never stall the master
  assert property (@(posedge clk) disable iff (reset)
    (bus_req.en && bus_req.addr[31:28] == 4'hF) |-> !bus_rsp.wt)
    else report_fail("bus_rsp.wt", 32'(bus_rsp.wt), 32'h0);

  // RAM writes complete in their first cycle
  assert property (@(posedge clk) disable iff (reset)
    (bus_req.en && bus_req.wr && bus_req.addr < 32'h0000_1000) |-> !bus_rsp.wt)
    else report_fail("bus_rsp.wt", 32'(bus_rsp.wt), 32'h0);

  // one transfer that starts and ends 1 unit after a rising edge
  task automatic bus_xfer(input logic wr, input logic [31:0] addr, input int size,
                          input logic [31:0] wdata, output logic [31:0] rdata);
    logic ram_rd;
    logic done;
    int   n;
    ram_rd = !wr && (addr < 32'h0000_1000);
    n = 0;
    done = 1'b0;
    rdata = 32'h0;
    bus_req.en = 1'b1;
    bus_req.wr = wr;
    bus_req.size = eco_pkg::bus_size_e'(size);
    bus_req.addr = addr;
    bus_req.data = wdata;
    while (!done) begin
      @(negedge clk);
      n++;
      // only RAM reads wait and only in their first cycle
      check_value("bus_rsp.wt", 32'(bus_rsp.wt), 32'(ram_rd && n == 1));
      done = !bus_rsp.wt;
      rdata = bus_rsp.data;
      @(posedge clk);
      #1;
    end
    bus_req.en = 1'b0;
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_xfer(1'b1, addr, 2, data, unused);
  endtask

  task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
    bus_xfer(1'b0, addr, 2, 32'h0, data);
  endtask

  task automatic shadow_write(input logic [31:0] a, input int sz, input logic [31:0] d);
    case (sz)
      0: begin
        shadow[a[11:0]] = d[7:0];
      end
      1: begin
        shadow[{a[11:1], 1'b0}] = d[15:8];
        shadow[{a[11:1], 1'b1}] = d[7:0];
      end
      default: begin
        for (int k = 0; k < 4; k++) begin
          shadow[{a[11:2], 2'(k)}] = d[31-8*k -: 8];
        end
      end
    endcase
  endtask

  function automatic logic [31:0] shadow_read(input logic [31:0] a, input int sz);
    case (sz)
      0: return {24'h000000, shadow[a[11:0]]};
      1: return {16'h0000, shadow[{a[11:1], 1'b0}], shadow[{a[11:1], 1'b1}]};
      default: return {shadow[{a[11:2], 2'd0}], shadow[{a[11:2], 2'd1}],
                       shadow[{a[11:2], 2'd2}], shadow[{a[11:2], 2'd3}]};
    endcase
  endfunction

  task automatic ram_test();
    logic [31:0] addr [60];
    int          wsz [60];
    int          rs;
    logic [31:0] span;
    logic [31:0] ra;
    logic [31:0] wd;
    logic [31:0] rd;
    for (int i = 0; i < 60; i++) begin
      wsz[i] = $unsigned($random(seed)) % 3;
      addr[i] = $random(seed) & 32'h0000_0FFF & ~((32'd1 << wsz[i]) - 1);
      wd = $random(seed);
      bus_xfer(1'b1, addr[i], wsz[i], wd, rd);
      shadow_write(addr[i], wsz[i], wd);
    end
    // read back inside each written span so every byte is defined
    for (int i = 0; i < 60; i++) begin
      rs = $unsigned($random(seed)) % (wsz[i] + 1);
      span = 32'd1 << wsz[i];
      ra = addr[i] | ($random(seed) & (span - 1) & ~((32'd1 << rs) - 1));
      bus_xfer(1'b0, ra, rs, 32'h0, rd);
      check_value("bus_rsp.data", rd, shadow_read(ra, rs));
    end
  endtask

  // waits for one timer irq and checks its distance from start
  task automatic wait_irq_rise(input bit tmr1, input int start, input int period,
                               output int rise);
    int   limit;
    logic hit;
    limit = cycle + period + 4;
    hit = 1'b0;
    rise = 0;
    while (!hit && cycle < limit) begin
      @(negedge clk);
      hit = tmr1 ? irq.tmr1 : irq.tmr0;
      rise = cycle;
      if (tmr1) begin
        check_value("irq.tmr0", 32'(irq.tmr0), 32'h0);
      end else begin
        check_value("irq.tmr1", 32'(irq.tmr1), 32'h0);
      end
    end
    if (!hit) begin
      report_error("timer interrupt did not rise within its period");
    end
    check_value(tmr1 ? "irq.tmr1 delay" : "irq.tmr0 delay", rise - start, period);
    @(posedge clk);
    #1;
  endtask

  task automatic timer0_test();
    int          start;
    int          rise;
    logic [31:0] rd;
    write_word(eco_pkg::tmr0_base, 32'h1);
    write_word(eco_pkg::tmr0_base + 32'h4, 32'd20);
    start = cycle;
    wait_irq_rise(1'b0, start, 20, rise);
    read_word(eco_pkg::tmr0_base, rd);
    check_value("tmr0 control", rd, 32'h3);
    repeat (3) begin
      @(negedge clk);
      check_value("irq.tmr0", 32'(irq.tmr0), 32'h1);
    end
    @(posedge clk);
    #1;
    write_word(eco_pkg::tmr0_base, 32'h1);
    @(negedge clk);
    check_value("irq.tmr0", 32'(irq.tmr0), 32'h0);
    @(posedge clk);
    #1;
    wait_irq_rise(1'b0, rise, 20, rise);
    write_word(eco_pkg::tmr0_base, 32'h0);
  endtask

  task automatic timer1_test();
    int          start;
    int          rise;
    logic [31:0] rd;
    write_word(eco_pkg::tmr1_base, 32'h1);
    write_word(eco_pkg::tmr1_base + 32'h4, 32'd7);
    start = cycle;
    wait_irq_rise(1'b1, start, 7, rise);
    read_word(eco_pkg::tmr1_base + 32'h8, rd);
    assert (rd >= 32'd1 && rd <= 32'd7)
      else report_error($sformatf("Fail tmr1 counter %h outside 00000001..00000007", rd));
    write_word(eco_pkg::tmr1_base, 32'h1);
    @(negedge clk);
    check_value("irq.tmr1", 32'(irq.tmr1), 32'h0);
    @(posedge clk);
    #1;
    wait_irq_rise(1'b1, rise, 7, rise);
    write_word(eco_pkg::tmr1_base, 32'h0);
  endtask

  task automatic bio_test();
    logic [31:0] rd;
    logic [3:0]  sw_val;
    led_val = 8'($random(seed));
    write_word(eco_pkg::bio_base, {24'h000000, led_val});
    @(negedge clk);
    check_value("led", 32'(led), 32'(led_val));
    @(posedge clk);
    #1;
    read_word(eco_pkg::bio_base, rd);
    check_value("bus_rsp.data", rd, {24'h000000, led_val});
    repeat (2) begin
      sw_val = 4'($random(seed));
      sw = sw_val;
      repeat (3) @(posedge clk);
      #1;
      read_word(eco_pkg::bio_base + 32'h4, rd);
      check_value("bus_rsp.data", rd, {28'h0000000, sw_val});
    end
  endtask

  task automatic unmapped_test();
    logic [31:0] rd;
    logic [31:0] wd;
    // word 0 would be hit if the write leaked into RAM
    wd = $random(seed);
    write_word(32'h0000_0000, wd);
    shadow_write(32'h0000_0000, 2, wd);
    read_word(32'h8000_0000, rd);
    check_value("bus_rsp.data", rd, 32'h0);
    wd = $random(seed);
    write_word(32'h8000_0000, {wd[31:8], ~led_val} | 32'h1);
    read_word(32'h0000_0000, rd);
    check_value("bus_rsp.data", rd, shadow_read(32'h0000_0000, 2));
    read_word(eco_pkg::tmr0_base + 32'h4, rd);
    check_value("tmr0 divisor", rd, 32'd20);
    read_word(eco_pkg::tmr1_base + 32'h4, rd);
    check_value("tmr1 divisor", rd, 32'd7);
    read_word(eco_pkg::tmr0_base, rd);
    check_value("tmr0 ien", 32'(rd[0]), 32'h0);
    read_word(eco_pkg::tmr1_base, rd);
    check_value("tmr1 ien", 32'(rd[0]), 32'h0);
    read_word(eco_pkg::bio_base, rd);
    check_value("bus_rsp.data", rd, {24'h000000, led_val});
    check_value("led", 32'(led), 32'(led_val));
  endtask

  initial begin
    bus_req = '0;
    sw = 4'h0;
    reset = 1'b1;
    seed = 44446;
    cycle = 0;
    led_val = 8'h00;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    ram_test();
    timer0_test();
    timer1_test();
    bio_test();
    unmapped_test();
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire
